/* files.f */
+incdir+bench
hdl/game_pkg.sv
hdl/plot_bus_if.sv
hdl/frame_ticker.sv
hdl/sprite_painter.sv
hdl/player_engine.sv
hdl/enemy_engine.sv
hdl/plot_arbiter.sv
hdl/game_referee.sv
hdl/dodge_game.sv
bench/dodge_game_tb.sv

/* Bender.yml */
package:
  name: dodge_game

sources:
  - files:
      - hdl/game_pkg.sv
      - hdl/plot_bus_if.sv
      - hdl/frame_ticker.sv
      - hdl/sprite_painter.sv
      - hdl/player_engine.sv
      - hdl/enemy_engine.sv
      - hdl/plot_arbiter.sv
      - hdl/game_referee.sv
      - hdl/dodge_game.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/dodge_game_tb.sv

/* bench/dodge_game_tests.svh */
`ifndef DODGE_GAME_TESTS_SVH
`define DODGE_GAME_TESTS_SVH

////////////////////
// Start-up.

task automatic initial_paint();
	coord_t start_x[3];
	coord_t start_y[3];
	start_x = '{PLAYER_X0, ENEMY0_X, ENEMY1_X};
	start_y = '{PLAYER_Y, ENEMY_Y0, ENEMY_Y0};
	for (int k = 0; k < 3; k++) begin
		take_job();  // Priority order.
		check("job_owner", k, job_kind);
		check("plot_x", start_x[k], job_ox);
		check("plot_x", start_x[k], job_nx);
		check("plot_y", start_y[k], job_oy);
		check("plot_y", start_y[k], job_ny);
	end
endtask

task automatic idle_when_ready();
	press_key(KEY_LEFT);
	repeat (5 * FRAME_LEN) @(posedge clock);
	check("plot_writes", 0, wr_x.size());
	@(negedge clock);
	check("won", 0, won);
	check("lost", 0, lost);
endtask

////////////////////
// Playing.

task automatic player_steering();
	press_key(KEY_START);
	press_key(KEY_RIGHT);
	wait_player_job();
	check("player_x", PLAYER_X0, job_ox);
	check("player_x", PLAYER_X0 + 1, job_nx);
	press_key(KEY_LEFT);  // Previous job is done by now.
	wait_player_job();
	check("player_x", PLAYER_X0 + 1, job_ox);
	check("player_x", PLAYER_X0, job_nx);
endtask

task automatic enemy_fall_wrap();
	int n;
	n        = 0;
	job_kind = -1;
	job_wrap = 1'b0;
	while (!(job_kind == 1 && job_wrap) && n < MAX_JOBS) begin
		take_job();
		if (job_kind < 0) begin
			break;
		end
		n++;
	end
	if (job_kind == 1 && job_wrap) begin
		check("enemy0_y", SCREEN_H - SPRITE_SIZE, job_oy);
		check("enemy0_y", ENEMY_Y0, job_ny);
	end else begin
		report_error("enemy0 never wrapped back to the top row");
	end
endtask

task automatic win_by_passes();
	int n;
	int extra;
	n = 0;
	@(negedge clock);
	check("won", 0, won);  // At most one lap so far.
	while (passes_seen < WIN_PASSES && n < MAX_JOBS) begin
		take_job();
		if (job_kind < 0) begin
			break;
		end
		n++;
	end
	if (passes_seen < WIN_PASSES) begin
		report_error("the enemies did not pass often enough for a win");
	end
	@(negedge clock);
	check("won", 1, won);
	check("lost", 0, lost);
	repeat (3 * FRAME_LEN) @(posedge clock);
	extra = 0;
	// Only the other enemy's job from the same frame may still finish.
	while (wr_x.size() >= JOB_PIXELS) begin
		take_job();
		extra++;
	end
	if (extra > 1) begin
		report_error("enemy paint jobs kept starting after the win");
	end
	repeat (5 * FRAME_LEN) @(posedge clock);
	check("plot_writes", 0, wr_x.size());
endtask

task automatic lose_by_collision();
	int n;
	apply_reset();
	initial_paint();
	press_key(KEY_START);
	n = 0;
	while (player_col > ENEMY0_X && n < PLAYER_X0) begin
		press_key(KEY_LEFT);
		wait_player_job();
		if (job_kind != 0) begin
			break;
		end
		n++;
	end
	check("player_x", ENEMY0_X, player_col);
	n = 0;
	@(negedge clock);
	while (lost !== 1'b1 && n < MAX_JOBS) begin
		take_job();
		if (job_kind < 0) begin
			break;
		end
		@(negedge clock);
		n++;
	end
	check("lost", 1, lost);
	check("won", 0, won);
	repeat (3 * FRAME_LEN) @(posedge clock);
	while (wr_x.size() >= JOB_PIXELS) begin
		take_job();
	end
	check("enemy0_y", PLAYER_Y - SPRITE_SIZE + 1, last_y[0]);  // First row touching the player.
	repeat (5 * FRAME_LEN) @(posedge clock);
	check("plot_writes", 0, wr_x.size());
endtask

`endif

/* bench/dodge_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dodge_game_tb import game_pkg::*; ();

	localparam int CLK_PERIOD     = 10;
	localparam int FRAME_LEN      = 200;                       // Cycles per frame here.
	localparam int SQUARE         = SPRITE_SIZE * SPRITE_SIZE;
	localparam int JOB_PIXELS     = 2 * SQUARE;                // Erase then draw.
	localparam int WRAP_FRAMES    = SCREEN_H - SPRITE_SIZE + 1;  // One enemy lap.
	localparam int JOB_WAIT       = 4 * FRAME_LEN;
	localparam int MAX_JOBS       = 8 * WRAP_FRAMES;
	localparam int WORST_FRAMES   = 3 * WRAP_FRAMES + 40;      // Two laps to win, one to lose.
	localparam int TIMEOUT_CYCLES = 2 * WORST_FRAMES * FRAME_LEN;

	bit         clock;
	logic       arst_n;
	logic [7:0] key_code;
	logic       key_valid;
	logic       plot;
	coord_t     plot_x;
	coord_t     plot_y;
	colour_t    plot_colour;
	logic       won;
	logic       lost;

	// Every plot write, oldest first.
	coord_t  wr_x[$];
	coord_t  wr_y[$];
	colour_t wr_c[$];

	int     errors;
	int     checks;
	int     job_kind;  // 0 player, 1 enemy0, 2 enemy1, -1 none.
	logic   job_wrap;
	coord_t job_ox;
	coord_t job_oy;
	coord_t job_nx;
	coord_t job_ny;
	coord_t player_col;
	coord_t last_y[2];
	int     player_jobs;
	int     enemy_jobs[2];
	int     passes_seen;

	dodge_game #(
		.FRAME_CYCLES(FRAME_LEN)
	) u_dodge_game (
		.clock      (clock),
		.arst_n     (arst_n),
		.key_code   (key_code),
		.key_valid  (key_valid),
		.plot       (plot),
		.plot_x     (plot_x),
		.plot_y     (plot_y),
		.plot_colour(plot_colour),
		.won        (won),
		.lost       (lost)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////
	// Plot monitor.

	always @(negedge clock) begin
		if (!arst_n) begin
			if (plot === 1'b1) begin
				report_error("plot was written while reset was asserted");
			end
		end else if (plot === 1'b1) begin
			wr_x.push_back(plot_x);
			wr_y.push_back(plot_y);
			wr_c.push_back(plot_colour);
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		report_error($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////
	// Helpers.

	task automatic report_error(input string what);
		errors++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1;
		arst_n    = 1'b0;
		key_valid = 1'b0;
		key_code  = 8'h00;
		repeat (4) @(posedge clock);
		#1;
		wr_x.delete();  // Jobs cut short by reset.
		wr_y.delete();
		wr_c.delete();
		player_col    = PLAYER_X0;
		last_y[0]     = ENEMY_Y0;
		last_y[1]     = ENEMY_Y0;
		player_jobs   = 0;
		enemy_jobs[0] = 0;
		enemy_jobs[1] = 0;
		passes_seen   = 0;
		arst_n        = 1'b1;
	endtask

	task automatic press_key(input logic [7:0] code);
		@(posedge clock);
		#1;
		key_code  = code;
		key_valid = 1'b1;
		@(posedge clock);
		#1;
		key_valid = 1'b0;
		key_code  = 8'h00;
	endtask

	// Pops one paint job, checks its two squares and tracks the sprite it belongs to.
	task automatic take_job();
		int      waited;
		int      p;
		int      idx;
		coord_t  base_x;
		coord_t  base_y;
		coord_t  exp_y;
		colour_t want_c;
		colour_t sprite_c;
		waited   = 0;
		job_kind = -1;
		job_wrap = 1'b0;
		while (wr_x.size() < JOB_PIXELS && waited < JOB_WAIT) begin
			@(posedge clock);
			waited++;
		end
		if (wr_x.size() < JOB_PIXELS) begin
			report_error($sformatf("no complete paint job within %0d cycles", JOB_WAIT));
			return;
		end
		job_ox   = wr_x[0];
		job_oy   = wr_y[0];
		job_nx   = wr_x[SQUARE];
		job_ny   = wr_y[SQUARE];
		sprite_c = wr_c[SQUARE];
		for (int i = 0; i < JOB_PIXELS; i++) begin
			p      = i % SQUARE;
			base_x = (i < SQUARE) ? job_ox : job_nx;
			base_y = (i < SQUARE) ? job_oy : job_ny;
			want_c = (i < SQUARE) ? BG_COLOUR : sprite_c;
			check("plot_x", base_x + p % SPRITE_SIZE, wr_x.pop_front());  // Row-major.
			check("plot_y", base_y + p / SPRITE_SIZE, wr_y.pop_front());
			check("plot_colour", want_c, wr_c.pop_front());
		end
		if (sprite_c == PLAYER_COLOUR) begin
			job_kind = 0;
			check("player_x", player_col, job_ox);
			check("player_y", PLAYER_Y, job_oy);
			check("player_y", PLAYER_Y, job_ny);
			if (player_jobs == 0) begin
				check("player_x", PLAYER_X0, job_nx);
			end
			player_col = job_nx;
			player_jobs++;
		end else if (sprite_c == ENEMY_COLOUR &&
				(job_nx == ENEMY0_X || job_nx == ENEMY1_X)) begin
			job_kind = (job_nx == ENEMY0_X) ? 1 : 2;
			idx      = job_kind - 1;
			check($sformatf("enemy%0d_x", idx), job_nx, job_ox);
			check($sformatf("enemy%0d_y", idx), last_y[idx], job_oy);
			if (enemy_jobs[idx] == 0) begin
				exp_y = ENEMY_Y0;  // Start square drawn in place.
			end else if (job_oy + 1 > SCREEN_H - SPRITE_SIZE) begin
				exp_y    = ENEMY_Y0;
				job_wrap = 1'b1;
				passes_seen++;
			end else begin
				exp_y = job_oy + 1'b1;
			end
			check($sformatf("enemy%0d_y", idx), exp_y, job_ny);
			last_y[idx] = job_ny;
			enemy_jobs[idx]++;
		end else begin
			report_error($sformatf("paint job with colour %0d at column %0d fits no sprite",
				sprite_c, job_nx));
		end
	endtask

	task automatic wait_player_job();
		int n;
		n        = 0;
		job_kind = -1;
		do begin
			take_job();
			n++;
		end while (job_kind > 0 && n < 8);
		if (job_kind != 0) begin
			report_error("no player paint job followed the key press");
		end
	endtask

	`include "dodge_game_tests.svh"

	////////////////////
	// Test sequence.

	initial begin
		arst_n    = 1'b0;
		key_code  = 8'h00;
		key_valid = 1'b0;
		apply_reset();
		initial_paint();
		idle_when_ready();
		player_steering();
		enemy_fall_wrap();
		win_by_passes();
		lose_by_collision();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/dodge_game.sv */
`timescale 1ns/1ps
`default_nettype none

module dodge_game import game_pkg::*; #(
	parameter int FRAME_CYCLES = game_pkg::FRAME_CYCLES
) (
	input  bit         clock,
	input  logic       arst_n,
	input  logic [7:0] key_code,
	input  logic       key_valid,
	output logic       plot,
	output coord_t     plot_x,
	output coord_t     plot_y,
	output colour_t    plot_colour,
	output logic       won,
	output logic       lost
);

	logic   tick;
	logic   playing;
	coord_t player_x;
	coord_t enemy0_y;
	coord_t enemy1_y;
	logic   enemy0_passed;
	logic   enemy1_passed;

	plot_bus_if player_bus ();
	plot_bus_if enemy0_bus ();
	plot_bus_if enemy1_bus ();

	////////////////////
	// Sprite engines.

	frame_ticker #(
		.RATE(FRAME_CYCLES)
	) u_frame_ticker (
		.clock (clock),
		.arst_n(arst_n),
		.tick  (tick)
	);

	player_engine u_player (
		.clock    (clock),
		.arst_n   (arst_n),
		.playing  (playing),
		.key_code (key_code),
		.key_valid(key_valid),
		.player_x (player_x),
		.bus      (player_bus)
	);

	enemy_engine #(
		.START_X(ENEMY0_X)
	) u_enemy0 (
		.clock  (clock),
		.arst_n (arst_n),
		.tick   (tick),
		.playing(playing),
		.enemy_y(enemy0_y),
		.passed (enemy0_passed),
		.bus    (enemy0_bus)
	);

	enemy_engine #(
		.START_X(ENEMY1_X)
	) u_enemy1 (
		.clock  (clock),
		.arst_n (arst_n),
		.tick   (tick),
		.playing(playing),
		.enemy_y(enemy1_y),
		.passed (enemy1_passed),
		.bus    (enemy1_bus)
	);

	////////////////////
	// Plot port and game control.

	plot_arbiter u_plot_arbiter (
		.clock      (clock),
		.arst_n     (arst_n),
		.m_player   (player_bus),  // Highest priority.
		.m_enemy0   (enemy0_bus),
		.m_enemy1   (enemy1_bus),
		.plot       (plot),
		.plot_x     (plot_x),
		.plot_y     (plot_y),
		.plot_colour(plot_colour)
	);

	game_referee u_game_referee (
		.clock        (clock),
		.arst_n       (arst_n),
		.key_code     (key_code),
		.key_valid    (key_valid),
		.player_x     (player_x),
		.enemy0_y     (enemy0_y),
		.enemy1_y     (enemy1_y),
		.enemy0_passed(enemy0_passed),
		.enemy1_passed(enemy1_passed),
		.playing      (playing),
		.won          (won),
		.lost         (lost)
	);

endmodule

`default_nettype wire

/* hdl/game_referee.sv */
`timescale 1ns/1ps
`default_nettype none

module game_referee import game_pkg::*; (
	input  bit         clock,
	input  logic       arst_n,
	input  logic [7:0] key_code,
	input  logic       key_valid,
	input  coord_t     player_x,
	input  coord_t     enemy0_y,
	input  coord_t     enemy1_y,
	input  logic       enemy0_passed,
	input  logic       enemy1_passed,
	output logic       playing,
	output logic       won,
	output logic       lost
);

	typedef logic [$clog2(WIN_PASSES + 2)-1:0] pass_count_t;  // Room for two at once.

	game_state_t state;
	pass_count_t passes;
	pass_count_t pass_total;
	logic        hit0;
	logic        hit1;

	// Two squares of the same size overlap.
	function automatic logic overlaps(coord_t ax, coord_t ay, coord_t bx, coord_t by);
		return ax + SPRITE_SIZE > bx && bx + SPRITE_SIZE > ax &&
			ay + SPRITE_SIZE > by && by + SPRITE_SIZE > ay;
	endfunction

	assign hit0       = overlaps(ENEMY0_X, enemy0_y, player_x, PLAYER_Y);
	assign hit1       = overlaps(ENEMY1_X, enemy1_y, player_x, PLAYER_Y);
	assign pass_total = passes + pass_count_t'(enemy0_passed) + pass_count_t'(enemy1_passed);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state  <= READY;
			passes <= '0;
		end else begin
			case (state)
				READY: begin
					if (key_valid && key_code == KEY_START) begin
						state <= PLAYING;
					end
				end
				PLAYING: begin
					passes <= pass_total;
					if (hit0 || hit1) begin
						state <= LOST;  // Beats a win in the same cycle.
					end else if (pass_total >= WIN_PASSES) begin
						state <= WON;
					end
				end
				default: state <= state;  // Held until reset.
			endcase
		end
	end

	assign playing = state == PLAYING;
	assign won     = state == WON;
	assign lost    = state == LOST;

endmodule

`default_nettype wire

/* hdl/plot_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module plot_arbiter import game_pkg::*; (
	input  bit        clock,
	input  logic      arst_n,
	plot_bus_if.slave m_player,
	plot_bus_if.slave m_enemy0,
	plot_bus_if.slave m_enemy1,
	output logic      plot,
	output coord_t    plot_x,
	output coord_t    plot_y,
	output colour_t   plot_colour
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_PLAYER,
		GNT_ENEMY0,
		GNT_ENEMY1
	} grant_t;

	grant_t  grant;
	logic    sel_cyc;
	logic    sel_stb;
	logic    sel_we;
	coord_t  sel_x;
	coord_t  sel_y;
	colour_t sel_colour;
	logic    ack_q;
	logic    hit;

	always_comb begin
		sel_cyc    = 1'b0;
		sel_stb    = 1'b0;
		sel_we     = 1'b0;
		sel_x      = m_player.x;
		sel_y      = m_player.y;
		sel_colour = m_player.colour;
		case (grant)
			GNT_PLAYER: begin
				sel_cyc = m_player.cyc;
				sel_stb = m_player.stb;
				sel_we  = m_player.we;
			end
			GNT_ENEMY0: begin
				sel_cyc    = m_enemy0.cyc;
				sel_stb    = m_enemy0.stb;
				sel_we     = m_enemy0.we;
				sel_x      = m_enemy0.x;
				sel_y      = m_enemy0.y;
				sel_colour = m_enemy0.colour;
			end
			GNT_ENEMY1: begin
				sel_cyc    = m_enemy1.cyc;
				sel_stb    = m_enemy1.stb;
				sel_we     = m_enemy1.we;
				sel_x      = m_enemy1.x;
				sel_y      = m_enemy1.y;
				sel_colour = m_enemy1.colour;
			end
			default: ;
		endcase
	end

	assign hit = sel_cyc && sel_stb && !ack_q;  // One ack per strobe.

	////////////////////
	// Grant and acknowledge.

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			grant <= GNT_NONE;
			ack_q <= 1'b0;
			plot  <= 1'b0;
		end else begin
			ack_q <= hit;
			plot  <= hit && sel_we;
			if (grant == GNT_NONE) begin
				if (m_player.cyc) begin
					grant <= GNT_PLAYER;
				end else if (m_enemy0.cyc) begin
					grant <= GNT_ENEMY0;
				end else if (m_enemy1.cyc) begin
					grant <= GNT_ENEMY1;
				end
			end else if (!sel_cyc) begin
				grant <= GNT_NONE;  // Job finished.
			end
		end
	end

	always_ff @(posedge clock) begin
		if (hit) begin
			plot_x      <= sel_x;
			plot_y      <= sel_y;
			plot_colour <= sel_colour;
		end
	end

	assign m_player.ack = ack_q && grant == GNT_PLAYER;
	assign m_enemy0.ack = ack_q && grant == GNT_ENEMY0;
	assign m_enemy1.ack = ack_q && grant == GNT_ENEMY1;

endmodule

`default_nettype wire

/* hdl/enemy_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module enemy_engine import game_pkg::*; #(
	parameter coord_t START_X = ENEMY0_X
) (
	input  bit         clock,
	input  logic       arst_n,
	input  logic       tick,
	input  logic       playing,
	output coord_t     enemy_y,
	output logic       passed,
	plot_bus_if.master bus
);

	logic   busy;
	logic   init_pending;
	logic   step;
	logic   wrap;
	coord_t next_y;

	assign step   = tick && playing && !busy;  // Frames during a job are lost.
	assign wrap   = enemy_y >= SCREEN_H - SPRITE_SIZE;
	assign next_y = wrap ? ENEMY_Y0 : enemy_y + 1'b1;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			enemy_y      <= ENEMY_Y0;
			passed       <= 1'b0;
			init_pending <= 1'b1;
		end else begin
			init_pending <= 1'b0;
			passed       <= step && wrap;
			if (step) begin
				enemy_y <= next_y;
			end
		end
	end

	sprite_painter #(
		.COLOUR(ENEMY_COLOUR)
	) u_painter (
		.clock (clock),
		.arst_n(arst_n),
		.start (init_pending || step),
		.old_x (START_X),
		.old_y (enemy_y),
		.new_x (START_X),
		.new_y (step ? next_y : enemy_y),
		.busy  (busy),
		.bus   (bus)
	);

endmodule

`default_nettype wire

/* hdl/player_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module player_engine import game_pkg::*; (
	input  bit         clock,
	input  logic       arst_n,
	input  logic       playing,
	input  logic [7:0] key_code,
	input  logic       key_valid,
	output coord_t     player_x,
	plot_bus_if.master bus
);

	logic   busy;
	logic   init_pending;  // Paint the start square once.
	logic   move;
	coord_t next_x;

	assign move = playing && !busy && key_valid &&
		(key_code == KEY_LEFT || key_code == KEY_RIGHT);

	// Clamp to the screen edges.
	always_comb begin
		next_x = player_x;
		if (key_code == KEY_LEFT && player_x > 0) begin
			next_x = player_x - 1'b1;
		end else if (key_code == KEY_RIGHT && player_x < SCREEN_W - SPRITE_SIZE) begin
			next_x = player_x + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			player_x     <= PLAYER_X0;
			init_pending <= 1'b1;
		end else begin
			init_pending <= 1'b0;
			if (move) begin
				player_x <= next_x;  // Committed even if the clamp held it.
			end
		end
	end

	sprite_painter #(
		.COLOUR(PLAYER_COLOUR)
	) u_painter (
		.clock (clock),
		.arst_n(arst_n),
		.start (init_pending || move),
		.old_x (player_x),
		.old_y (PLAYER_Y),
		.new_x (move ? next_x : player_x),
		.new_y (PLAYER_Y),
		.busy  (busy),
		.bus   (bus)
	);

endmodule

`default_nettype wire

/* hdl/sprite_painter.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_painter import game_pkg::*; #(
	parameter colour_t COLOUR = PLAYER_COLOUR
) (
	input  bit         clock,
	input  logic       arst_n,
	input  logic       start,
	input  coord_t     old_x,
	input  coord_t     old_y,
	input  coord_t     new_x,
	input  coord_t     new_y,
	output logic       busy,
	plot_bus_if.master bus
);

	typedef enum logic [1:0] {
		IDLE,
		ERASE,
		DRAW,
		WAIT_ACK
	} paint_state_t;

	typedef logic [$clog2(SPRITE_SIZE)-1:0] offset_t;

	paint_state_t state;
	logic         cyc;
	logic         stb;
	logic         drawing;  // Pixel on the bus belongs to the new square.
	offset_t      col;
	offset_t      row;
	coord_t       erase_x;
	coord_t       erase_y;
	coord_t       draw_x;
	coord_t       draw_y;
	logic         last_pixel;

	assign busy       = state != IDLE;
	assign last_pixel = col == SPRITE_SIZE - 1 && row == SPRITE_SIZE - 1;

	// Both squares are sampled once per job.
	always_ff @(posedge clock) begin
		if (state == IDLE && start) begin
			erase_x <= old_x;
			erase_y <= old_y;
			draw_x  <= new_x;
			draw_y  <= new_y;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state   <= IDLE;
			cyc     <= 1'b0;
			stb     <= 1'b0;
			drawing <= 1'b0;
			col     <= '0;
			row     <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						cyc   <= 1'b1;  // Bus cycle spans the whole job.
						col   <= '0;
						row   <= '0;
						state <= ERASE;
					end
				end
				ERASE, DRAW: begin
					stb     <= 1'b1;
					drawing <= state == DRAW;
					state   <= WAIT_ACK;
				end
				WAIT_ACK: begin
					if (bus.ack) begin
						stb <= 1'b0;
						if (last_pixel) begin
							col <= '0;
							row <= '0;
							if (drawing) begin
								cyc   <= 1'b0;
								state <= IDLE;
							end else begin
								state <= DRAW;
							end
						end else begin
							if (col == SPRITE_SIZE - 1) begin  // Row-major walk.
								col <= '0;
								row <= row + 1'b1;
							end else begin
								col <= col + 1'b1;
							end
							state <= drawing ? DRAW : ERASE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bus.cyc    = cyc;
	assign bus.stb    = stb;
	assign bus.we     = 1'b1;
	assign bus.x      = (drawing ? draw_x : erase_x) + coord_t'(col);
	assign bus.y      = (drawing ? draw_y : erase_y) + coord_t'(row);
	assign bus.colour = drawing ? COLOUR : BG_COLOUR;

endmodule

`default_nettype wire

/* hdl/frame_ticker.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_ticker import game_pkg::*; #(
	parameter int RATE = FRAME_CYCLES
) (
	input  bit   clock,
	input  logic arst_n,
	output logic tick
);

	typedef logic [$clog2(RATE + 1)-1:0] count_t;

	count_t count;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count <= count_t'(RATE - 1);
			tick  <= 1'b0;
		end else if (count == '0) begin
			count <= count_t'(RATE - 1);  // Reload for the next frame.
			tick  <= 1'b1;
		end else begin
			count <= count - 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/plot_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface plot_bus_if import game_pkg::*; ();

	logic    cyc;     // Held for a whole paint job.
	logic    stb;     // One pixel per strobe.
	logic    we;
	coord_t  x;
	coord_t  y;
	colour_t colour;
	logic    ack;

	modport master (
		output cyc, stb, we, x, y, colour,
		input  ack
	);

	modport slave (
		input  cyc, stb, we, x, y, colour,
		output ack
	);

endinterface

`default_nettype wire

/* hdl/game_pkg.sv */
`default_nettype none

package game_pkg;

	////////////////////
	// Types.

	typedef logic [8:0] coord_t;   // Pixel column or row.
	typedef logic [2:0] colour_t;  // One bit per channel, {R, G, B}.

	typedef enum logic [1:0] {
		READY,
		PLAYING,
		WON,
		LOST
	} game_state_t;

	////////////////////
	// Screen and timing.

	localparam int SCREEN_W     = 320;
	localparam int SCREEN_H     = 240;
	localparam int SPRITE_SIZE  = 4;       // Edge of every square sprite.
	localparam int FRAME_CYCLES = 833333;  // 60 Hz frames from 50 MHz.

	localparam colour_t BG_COLOUR     = 3'd0;
	localparam colour_t PLAYER_COLOUR = 3'd2;  // Green.
	localparam colour_t ENEMY_COLOUR  = 3'd4;  // Red.

	// Set 2 make codes.
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_START = 8'h29;  // Space bar.

	////////////////////
	// Start positions.

	localparam coord_t PLAYER_X0 = 9'd156;
	localparam coord_t PLAYER_Y  = 9'd228;  // Player never leaves this row.
	localparam coord_t ENEMY0_X  = 9'd40;
	localparam coord_t ENEMY1_X  = 9'd260;
	localparam coord_t ENEMY_Y0  = 9'd0;

	localparam int WIN_PASSES = 3;  // Wraps of both enemies together.

endpackage

`default_nettype wire
